/* design/motor_regs_cfg.svh */
// ============================
// Motor register block config
// Widths, channel counts, address map and command bits
// ============================
`ifndef MOTOR_REGS_CFG_SVH
`define MOTOR_REGS_CFG_SVH

// Bus and register widths
`define MR_ADDR_W 6
`define MR_DATA_W 8

// Channel counts, drive motors come first in channel order
`define MR_NUM_DRIVE 4
`define MR_NUM_ROT 4
`define MR_NUM_CH (`MR_NUM_DRIVE + `MR_NUM_ROT)

// Motor side widths
`define MR_ANGLE_W 12       // Absolute angle from encoder
`define MR_TEMP_W 7         // ADC temperature

// Broadcast writes
`define MR_ADDR_BCAST_ALL 6'h01     // Every control register
`define MR_ADDR_BCAST_ROT 6'h02     // Rotation controls only
`define MR_ADDR_BCAST_DRIVE 6'h03   // Drive controls only

// Drive block, control then status per motor
`define MR_ADDR_DRIVE_BASE 6'h04
`define MR_DRIVE_STRIDE 2
`define MR_DRIVE_OFS_STATUS 1

// Rotation block, five addresses per motor
`define MR_ADDR_ROT_BASE 6'h0C
`define MR_ROT_STRIDE 5
`define MR_ROT_OFS_CTRL 0
`define MR_ROT_OFS_STATUS 1
`define MR_ROT_OFS_TARGET 2     // Target angle low byte
`define MR_ROT_OFS_CUR_LO 3
`define MR_ROT_OFS_CUR_HI 4     // Also the command address on write

// Command write bits
`define MR_ABORT_BIT 4
`define MR_UPDATE_BIT 5

`endif

/* design/motor_regs_pkg.sv */
// ============================
// Motor register types
// Bus, control, status and angle structs
// ============================
`include "motor_regs_cfg.svh"

package motor_regs_pkg;

    // Host register bus, plain strobes
    typedef struct packed {
        logic [`MR_ADDR_W-1:0] address;
        logic                  write_en;
        logic [`MR_DATA_W-1:0] wr_data;
        logic                  read_en;
    } host_bus_t;

    // Drive motor control byte
    typedef struct packed {
        logic                    brake;     // Bit 7
        logic                    enable;
        logic                    direction;
        logic [`MR_DATA_W-4:0]   pwm;       // 5 bit duty
    } drive_ctrl_t;

    // Rotation motor control byte
    typedef struct packed {
        logic                               brake;
        logic                               enable;
        logic                               direction;
        logic                               spare;      // Stored, no function
        logic [`MR_ANGLE_W-`MR_DATA_W-1:0]  target_hi;  // Target angle bits 11:8
    } rot_ctrl_t;

    // Raw status inputs from one motor
    typedef struct packed {
        logic                  fault;
        logic                  startup_fail;    // Stalled at startup
        logic [`MR_TEMP_W-1:0] adc_temp;
    } motor_status_t;

    // Feedback from a rotation loop
    typedef struct packed {
        logic [`MR_ANGLE_W-1:0] current_angle;
        logic                   angle_done;     // Arrived at target
    } angle_fb_t;

    // Command to a rotation loop
    typedef struct packed {
        logic [`MR_ANGLE_W-1:0] target_angle;
        logic                   update;     // One cycle, start move
        logic                   abort;      // One cycle, stop move
    } angle_cmd_t;

endpackage

/* design/reg_decoder.sv */
// ============================
// Register write decoder
// Bus writes to per-channel strobes, with broadcasts
// ============================
`include "motor_regs_cfg.svh"

module reg_decoder (
    input  logic                          clock,
    input  logic                          rst,
    input  motor_regs_pkg::host_bus_t     bus,
    output logic [`MR_NUM_CH-1:0]         ctrl_we,     // Drive channels low, rotation high
    output logic [`MR_NUM_ROT-1:0]        target_we,
    output logic [`MR_NUM_ROT-1:0]        cmd_we
);

    logic bcast_all;
    logic bcast_rot;
    logic bcast_drive;

    assign bcast_all   = (bus.address == `MR_ADDR_BCAST_ALL);
    assign bcast_rot   = (bus.address == `MR_ADDR_BCAST_ROT);
    assign bcast_drive = (bus.address == `MR_ADDR_BCAST_DRIVE);

    always_comb begin
        ctrl_we   = '0;
        target_we = '0;
        cmd_we    = '0;
        // Drive controls, own address or all/drive broadcast
        for (int n = 0; n < `MR_NUM_DRIVE; n++) begin
            ctrl_we[n] = bus.write_en &
                ((bus.address == `MR_ADDR_W'(`MR_ADDR_DRIVE_BASE + `MR_DRIVE_STRIDE * n)) |
                 bcast_all | bcast_drive);
        end
        // Rotation block, control plus target and command addresses
        for (int n = 0; n < `MR_NUM_ROT; n++) begin
            ctrl_we[`MR_NUM_DRIVE + n] = bus.write_en &
                ((bus.address == `MR_ADDR_W'(`MR_ADDR_ROT_BASE + `MR_ROT_STRIDE * n +
                                             `MR_ROT_OFS_CTRL)) |
                 bcast_all | bcast_rot);
            target_we[n] = bus.write_en &
                (bus.address == `MR_ADDR_W'(`MR_ADDR_ROT_BASE + `MR_ROT_STRIDE * n +
                                            `MR_ROT_OFS_TARGET));
            cmd_we[n] = bus.write_en &
                (bus.address == `MR_ADDR_W'(`MR_ADDR_ROT_BASE + `MR_ROT_STRIDE * n +
                                            `MR_ROT_OFS_CUR_HI));
        end
    end

    // Single address writes never hit two control registers
    a_ctrl_onehot: assert property (@(posedge clock) disable iff (rst)
        !(bcast_all | bcast_rot | bcast_drive) |-> $onehot0(ctrl_we));

endmodule

/* design/motor_channel.sv */
// ============================
// Motor channel
// Control register and sampled status byte
// ============================
`include "motor_regs_cfg.svh"

module motor_channel #(
    parameter type ctrl_t = logic [`MR_DATA_W-1:0]  // Drive or rotation layout
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          we,          // Own address or broadcast
    input  logic [`MR_DATA_W-1:0]         wr_data,
    input  motor_regs_pkg::motor_status_t status_in,
    output ctrl_t                         ctrl,
    output logic [`MR_DATA_W-1:0]         ctrl_byte,
    output logic [`MR_DATA_W-1:0]         status_byte
);

    // Control byte, cleared on reset
    always_ff @(posedge clock) begin
        if (rst) begin
            ctrl <= '0;
        end else if (we) begin
            ctrl <= ctrl_t'(wr_data);
        end
    end

    assign ctrl_byte = ctrl;    // Readback of the raw byte

    // Status sampled every cycle
    // Top temperature bit does not fit
    always_ff @(posedge clock) begin
        status_byte <= {status_in.fault,
                        status_in.startup_fail,
                        status_in.adc_temp[`MR_DATA_W-3:0]};
    end

    // Outputs to motor driver stay defined once out of reset
    a_ctrl_known: assert property (@(posedge clock) disable iff (rst)
        !$isunknown(ctrl));

endmodule

/* design/angle_tracker.sv */
// ============================
// Rotation angle tracker
// Target angle, feedback capture, update/abort pulses
// ============================
`include "motor_regs_cfg.svh"

module angle_tracker (
    input  logic                                 clock,
    input  logic                                 rst,
    input  logic                                 target_we,
    input  logic                                 cmd_we,
    input  logic [`MR_DATA_W-1:0]                wr_data,
    input  logic [`MR_ANGLE_W-`MR_DATA_W-1:0]    target_hi,  // From rotation control byte
    input  motor_regs_pkg::angle_fb_t            fb,
    output motor_regs_pkg::angle_cmd_t           cmd,
    output logic [`MR_DATA_W-1:0]                target_lo_byte,
    output logic [`MR_DATA_W-1:0]                cur_lo_byte,
    output logic [`MR_DATA_W-1:0]                cur_hi_byte
);

    logic update_q;
    logic abort_q;

    // Target low byte
    always_ff @(posedge clock) begin
        if (rst) begin
            target_lo_byte <= '0;
        end else if (target_we) begin
            target_lo_byte <= wr_data;
        end
    end

    // Pulses, one cycle per command write
    // Back to back writes give back to back pulses
    always_ff @(posedge clock) begin
        if (rst) begin
            update_q <= 1'b0;
            abort_q  <= 1'b0;
        end else begin
            update_q <= cmd_we & wr_data[`MR_UPDATE_BIT];
            abort_q  <= cmd_we & wr_data[`MR_ABORT_BIT];
        end
    end

    // Feedback capture every cycle
    always_ff @(posedge clock) begin
        cur_lo_byte <= fb.current_angle[`MR_DATA_W-1:0];
        cur_hi_byte <= {fb.angle_done, 3'b000,
                        fb.current_angle[`MR_ANGLE_W-1:`MR_DATA_W]};   // Done, pad, top nibble
    end

    assign cmd.target_angle = {target_hi, target_lo_byte};   // High nibble lives in control
    assign cmd.update       = update_q;
    assign cmd.abort        = abort_q;

    // No pulse without the matching command write a cycle earlier
    a_update_src: assert property (@(posedge clock) disable iff (rst)
        cmd.update |-> $past(cmd_we & wr_data[`MR_UPDATE_BIT]));
    a_abort_src: assert property (@(posedge clock) disable iff (rst)
        cmd.abort |-> $past(cmd_we & wr_data[`MR_ABORT_BIT]));

endmodule

/* design/reg_read_mux.sv */
// ============================
// Register read mux
// Address to byte select, registered onto rd_data
// ============================
`include "motor_regs_cfg.svh"

module reg_read_mux (
    input  logic                                    clock,
    input  logic                                    rst,
    input  motor_regs_pkg::host_bus_t               bus,
    input  logic [`MR_NUM_CH-1:0][`MR_DATA_W-1:0]   ctrl_bytes,
    input  logic [`MR_NUM_CH-1:0][`MR_DATA_W-1:0]   status_bytes,
    input  logic [`MR_NUM_ROT-1:0][`MR_DATA_W-1:0]  target_lo,
    input  logic [`MR_NUM_ROT-1:0][`MR_DATA_W-1:0]  cur_lo,
    input  logic [`MR_NUM_ROT-1:0][`MR_DATA_W-1:0]  cur_hi,
    output logic [`MR_DATA_W-1:0]                   rd_data
);

    logic [`MR_DATA_W-1:0] rd_next;
    logic [`MR_ADDR_W-1:0] rot_base;   // First address of rotation motor n

    always_comb begin
        rd_next  = '0;   // Reserved, broadcast and unmapped read as zero
        rot_base = '0;
        for (int n = 0; n < `MR_NUM_DRIVE; n++) begin
            if (bus.address == `MR_ADDR_W'(`MR_ADDR_DRIVE_BASE + `MR_DRIVE_STRIDE * n))
                rd_next = ctrl_bytes[n];
            if (bus.address == `MR_ADDR_W'(`MR_ADDR_DRIVE_BASE + `MR_DRIVE_STRIDE * n +
                                           `MR_DRIVE_OFS_STATUS))
                rd_next = status_bytes[n];
        end
        for (int n = 0; n < `MR_NUM_ROT; n++) begin
            rot_base = `MR_ADDR_W'(`MR_ADDR_ROT_BASE + `MR_ROT_STRIDE * n);
            if (bus.address == rot_base + `MR_ADDR_W'(`MR_ROT_OFS_CTRL))
                rd_next = ctrl_bytes[`MR_NUM_DRIVE + n];
            if (bus.address == rot_base + `MR_ADDR_W'(`MR_ROT_OFS_STATUS))
                rd_next = status_bytes[`MR_NUM_DRIVE + n];
            if (bus.address == rot_base + `MR_ADDR_W'(`MR_ROT_OFS_TARGET))
                rd_next = target_lo[n];
            if (bus.address == rot_base + `MR_ADDR_W'(`MR_ROT_OFS_CUR_LO))
                rd_next = cur_lo[n];
            if (bus.address == rot_base + `MR_ADDR_W'(`MR_ROT_OFS_CUR_HI))
                rd_next = cur_hi[n];
        end
    end

    // Holds between reads, old value on same cycle write
    always_ff @(posedge clock) begin
        if (rst) begin
            rd_data <= '0;
        end else if (bus.read_en) begin
            rd_data <= rd_next;
        end
    end

    // Every mapped source must be defined by the time it is read
    a_rd_known: assert property (@(posedge clock) disable iff (rst)
        !$isunknown(rd_data));

endmodule

/* design/motor_regs_top.sv */
// ============================
// Swerve drive register block
// Host bus to eight motor channels
// ============================
`include "motor_regs_cfg.svh"

module motor_regs_top (
    input  logic                          clock,
    input  logic                          rst,
    input  motor_regs_pkg::host_bus_t     bus,
    output logic [`MR_DATA_W-1:0]         rd_data,
    input  motor_regs_pkg::motor_status_t motor_status [`MR_NUM_CH],  // Drive first
    input  motor_regs_pkg::angle_fb_t     angle_fb [`MR_NUM_ROT],
    output motor_regs_pkg::drive_ctrl_t   drive_ctrl [`MR_NUM_DRIVE],
    output motor_regs_pkg::rot_ctrl_t     rot_ctrl [`MR_NUM_ROT],
    output motor_regs_pkg::angle_cmd_t    angle_cmd [`MR_NUM_ROT]
);

    logic [`MR_NUM_CH-1:0]                   ctrl_we;
    logic [`MR_NUM_ROT-1:0]                  target_we;
    logic [`MR_NUM_ROT-1:0]                  cmd_we;
    logic [`MR_NUM_CH-1:0][`MR_DATA_W-1:0]   ctrl_bytes;
    logic [`MR_NUM_CH-1:0][`MR_DATA_W-1:0]   status_bytes;
    logic [`MR_NUM_ROT-1:0][`MR_DATA_W-1:0]  target_lo;
    logic [`MR_NUM_ROT-1:0][`MR_DATA_W-1:0]  cur_lo;
    logic [`MR_NUM_ROT-1:0][`MR_DATA_W-1:0]  cur_hi;

    reg_decoder u_decoder (
        .clock     (clock),
        .rst       (rst),
        .bus       (bus),
        .ctrl_we   (ctrl_we),
        .target_we (target_we),
        .cmd_we    (cmd_we)
    );

    // Drive motors, channels 0..3
    for (genvar n = 0; n < `MR_NUM_DRIVE; n++) begin : g_drive
        motor_channel #(.ctrl_t(motor_regs_pkg::drive_ctrl_t)) u_chan (
            .clock       (clock),
            .rst         (rst),
            .we          (ctrl_we[n]),
            .wr_data     (bus.wr_data),
            .status_in   (motor_status[n]),
            .ctrl        (drive_ctrl[n]),
            .ctrl_byte   (ctrl_bytes[n]),
            .status_byte (status_bytes[n])
        );
    end

    // Rotation motors, channels 4..7
    for (genvar n = 0; n < `MR_NUM_ROT; n++) begin : g_rot
        motor_channel #(.ctrl_t(motor_regs_pkg::rot_ctrl_t)) u_chan (
            .clock       (clock),
            .rst         (rst),
            .we          (ctrl_we[`MR_NUM_DRIVE + n]),
            .wr_data     (bus.wr_data),
            .status_in   (motor_status[`MR_NUM_DRIVE + n]),
            .ctrl        (rot_ctrl[n]),
            .ctrl_byte   (ctrl_bytes[`MR_NUM_DRIVE + n]),
            .status_byte (status_bytes[`MR_NUM_DRIVE + n])
        );
    end

    // One tracker per rotation motor
    for (genvar n = 0; n < `MR_NUM_ROT; n++) begin : g_angle
        angle_tracker u_tracker (
            .clock          (clock),
            .rst            (rst),
            .target_we      (target_we[n]),
            .cmd_we         (cmd_we[n]),
            .wr_data        (bus.wr_data),
            .target_hi      (rot_ctrl[n].target_hi),   // Nibble from control byte
            .fb             (angle_fb[n]),
            .cmd            (angle_cmd[n]),
            .target_lo_byte (target_lo[n]),
            .cur_lo_byte    (cur_lo[n]),
            .cur_hi_byte    (cur_hi[n])
        );
    end

    reg_read_mux u_read_mux (
        .clock        (clock),
        .rst          (rst),
        .bus          (bus),
        .ctrl_bytes   (ctrl_bytes),
        .status_bytes (status_bytes),
        .target_lo    (target_lo),
        .cur_lo       (cur_lo),
        .cur_hi       (cur_hi),
        .rd_data      (rd_data)
    );

endmodule

/* sim/motor_regs_tb.sv */
// ==============================
// Motor register testbench
// Seeded random bus traffic against a register model
// ==============================
`include "motor_regs_cfg.svh"

module motor_regs_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 20;
    localparam int N_RESET    = 10;
    localparam int N_SINGLE   = 40;     // Write then readback
    localparam int N_BCAST    = 12;     // Each followed by eight control reads
    localparam int N_STATUS   = 16;
    localparam int N_CMD      = 24;
    localparam int N_MIXED    = 300;
    localparam int N_OPS      = N_SINGLE + N_BCAST + N_STATUS + N_CMD + N_MIXED;
    localparam int TIMEOUT_NS = (N_RESET + 12 * N_OPS + 100) * CLK_PERIOD;

    logic                          clock = 1'b0;
    logic                          rst;
    logic [`MR_DATA_W-1:0]         rd_data;
    motor_regs_pkg::host_bus_t     bus;
    motor_regs_pkg::motor_status_t motor_status [`MR_NUM_CH];
    motor_regs_pkg::angle_fb_t     angle_fb [`MR_NUM_ROT];
    motor_regs_pkg::drive_ctrl_t   drive_ctrl [`MR_NUM_DRIVE];
    motor_regs_pkg::rot_ctrl_t     rot_ctrl [`MR_NUM_ROT];
    motor_regs_pkg::angle_cmd_t    angle_cmd [`MR_NUM_ROT];
    int                            seed = 32'h3c7c_04db;

    // Register model, drive channels first
    logic [7:0] ctrl_m [`MR_NUM_CH];
    logic [7:0] status_m [`MR_NUM_CH];     // Sampled status bytes
    logic [7:0] target_lo_m [`MR_NUM_ROT];
    logic [7:0] cur_lo_m [`MR_NUM_ROT];
    logic [7:0] cur_hi_m [`MR_NUM_ROT];
    logic       upd_m [`MR_NUM_ROT];
    logic       abt_m [`MR_NUM_ROT];
    logic [7:0] rd_m;

    motor_regs_top dut (
        .clock        (clock),
        .rst          (rst),
        .bus          (bus),
        .rd_data      (rd_data),
        .motor_status (motor_status),
        .angle_fb     (angle_fb),
        .drive_ctrl   (drive_ctrl),
        .rot_ctrl     (rot_ctrl),
        .angle_cmd    (angle_cmd)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [5:0] rot_addr(input int n, input int ofs);
        return 6'(`MR_ADDR_ROT_BASE + `MR_ROT_STRIDE * n + ofs);
    endfunction

    // Control register of channel ch, status sits one above
    function automatic logic [5:0] ctrl_addr(input int ch);
        if (ch < `MR_NUM_DRIVE)
            return 6'(`MR_ADDR_DRIVE_BASE + `MR_DRIVE_STRIDE * ch);
        return rot_addr(ch - `MR_NUM_DRIVE, 0);
    endfunction

    // Byte a read returns, from the address map
    function automatic logic [7:0] read_model(input logic [5:0] addr);
        int a;
        int ofs;
        logic [7:0] v;
        a = int'(addr);
        v = 8'h00;                                      // Reserved, broadcast, unmapped
        if (a >= 4 && a < 12) begin
            ofs = (a - 4) % 2;
            v = (ofs == 0) ? ctrl_m[(a - 4) / 2] : status_m[(a - 4) / 2];
        end else if (a >= 12 && a < 32) begin
            case ((a - 12) % 5)
                0: v = ctrl_m[`MR_NUM_DRIVE + (a - 12) / 5];
                1: v = status_m[`MR_NUM_DRIVE + (a - 12) / 5];
                2: v = target_lo_m[(a - 12) / 5];
                3: v = cur_lo_m[(a - 12) / 5];
                default: v = cur_hi_m[(a - 12) / 5];
            endcase
        end
        return v;
    endfunction

    // Model update at a rising edge
    task automatic model_edge();
        int a;
        a = int'(bus.address);
        if (rst) begin
            ctrl_m      = '{default: 8'h00};
            target_lo_m = '{default: 8'h00};
            upd_m       = '{default: 1'b0};
            abt_m       = '{default: 1'b0};
            rd_m        = 8'h00;
        end else begin
            if (bus.read_en)
                rd_m = read_model(bus.address);     // Old value wins over same cycle write
            upd_m = '{default: 1'b0};
            abt_m = '{default: 1'b0};
            for (int ch = 0; ch < `MR_NUM_CH && bus.write_en; ch++) begin
                if (a == 1 || (a == 3 && ch < 4) || (a == 2 && ch >= 4) || a == int'(ctrl_addr(ch)))
                    ctrl_m[ch] = bus.wr_data;
            end
            if (bus.write_en && a >= 12 && a < 32 && (a - 12) % 5 == 2)
                target_lo_m[(a - 12) / 5] = bus.wr_data;
            if (bus.write_en && a >= 12 && a < 32 && (a - 12) % 5 == 4) begin
                upd_m[(a - 12) / 5] = bus.wr_data[5];
                abt_m[(a - 12) / 5] = bus.wr_data[4];
            end
        end
        for (int ch = 0; ch < `MR_NUM_CH; ch++) begin
            status_m[ch] = {motor_status[ch].fault, motor_status[ch].startup_fail,
                            motor_status[ch].adc_temp[5:0]};   // Top temp bit dropped
        end
        for (int n = 0; n < `MR_NUM_ROT; n++) begin
            cur_lo_m[n] = angle_fb[n].current_angle[7:0];
            cur_hi_m[n] = {angle_fb[n].angle_done, 3'b000, angle_fb[n].current_angle[11:8]};
        end
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        $display("Test failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic check_drive(input string name, input motor_regs_pkg::drive_ctrl_t got,
                               input motor_regs_pkg::drive_ctrl_t exp);
        if (got !== exp)
            report_mismatch(name, 16'(got), 16'(exp));
    endtask

    task automatic check_rot(input string name, input motor_regs_pkg::rot_ctrl_t got,
                             input motor_regs_pkg::rot_ctrl_t exp);
        if (got !== exp)
            report_mismatch(name, 16'(got), 16'(exp));
    endtask

    task automatic check_cmd(input string name, input motor_regs_pkg::angle_cmd_t got,
                             input motor_regs_pkg::angle_cmd_t exp);
        if (got !== exp)
            report_mismatch(name, 16'(got), 16'(exp));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            report_mismatch(name, 16'(got), 16'(exp));
    endtask

    // All outputs against the model, at the falling edge
    task automatic check_all();
        motor_regs_pkg::angle_cmd_t exp_cmd;
        for (int n = 0; n < `MR_NUM_DRIVE; n++) begin
            check_drive($sformatf("drive_ctrl[%0d]", n), drive_ctrl[n],
                        motor_regs_pkg::drive_ctrl_t'(ctrl_m[n]));
        end
        for (int n = 0; n < `MR_NUM_ROT; n++) begin
            check_rot($sformatf("rot_ctrl[%0d]", n), rot_ctrl[n],
                      motor_regs_pkg::rot_ctrl_t'(ctrl_m[`MR_NUM_DRIVE + n]));
            exp_cmd.target_angle = {ctrl_m[`MR_NUM_DRIVE + n][3:0], target_lo_m[n]};
            exp_cmd.update       = upd_m[n];
            exp_cmd.abort        = abt_m[n];
            check_cmd($sformatf("angle_cmd[%0d]", n), angle_cmd[n], exp_cmd);
        end
        check_byte("rd_data", rd_data, rd_m);
    endtask

    task automatic drive_bus(input logic [5:0] addr, input logic we, input logic [7:0] data,
                             input logic re);
        bus.address  = addr;
        bus.write_en = we;
        bus.wr_data  = data;
        bus.read_en  = re;
    endtask

    task automatic randomize_inputs();
        logic [31:0] r;
        for (int ch = 0; ch < `MR_NUM_CH; ch++) begin
            r = $random(seed);
            motor_status[ch] = r[8:0];
        end
        for (int n = 0; n < `MR_NUM_ROT; n++) begin
            r = $random(seed);
            angle_fb[n] = r[12:0];
        end
    endtask

    // One clock, inputs already set on the falling edge
    task automatic step();
        @(posedge clock);
        model_edge();
        @(negedge clock);
        check_all();
    endtask

    initial begin
        int ch;
        int pick;
        logic [5:0] addr;
        rst = 1'b1;
        drive_bus('0, 1'b0, '0, 1'b0);
        motor_status = '{default: '0};
        angle_fb     = '{default: '0};
        repeat (N_RESET)
            step();
        rst = 1'b0;     // Reset state checked on every step above
        for (int i = 0; i < N_SINGLE; i++) begin
            ch = rand_below(`MR_NUM_CH + `MR_NUM_ROT);   // Top four pick a target byte
            addr = (ch < `MR_NUM_CH) ? ctrl_addr(ch) : rot_addr(ch - `MR_NUM_CH, 2);
            drive_bus(addr, 1'b1, rand_byte(), 1'b0);
            step();
            drive_bus(addr, 1'b0, '0, 1'b1);
            step();
        end
        // Broadcasts, then every control byte and one zero address read back
        for (int i = 0; i < N_BCAST; i++) begin
            drive_bus(6'(1 + i % 3), 1'b1, rand_byte(), 1'b0);
            step();
            for (int c = 0; c < `MR_NUM_CH; c++) begin
                drive_bus(ctrl_addr(c), 1'b0, '0, 1'b1);
                step();
            end
            pick = rand_below(36);
            drive_bus((pick < 4) ? 6'(pick) : 6'(pick + 28), 1'b0, '0, 1'b1);
            step();
            check_byte("rd_data", rd_data, 8'h00);
        end
        for (int i = 0; i < N_STATUS; i++) begin
            randomize_inputs();
            drive_bus('0, 1'b0, '0, 1'b0);
            step();
            step();     // Held over two edges
            drive_bus(ctrl_addr(rand_below(`MR_NUM_CH)) + 6'd1, 1'b0, '0, 1'b1);
            step();
            ch = rand_below(`MR_NUM_ROT);
            drive_bus(rot_addr(ch, 3), 1'b0, '0, 1'b1);
            step();
            drive_bus(rot_addr(ch, 4), 1'b0, '0, 1'b1);
            step();
        end
        for (int i = 0; i < N_CMD; i++) begin
            drive_bus(rot_addr(rand_below(`MR_NUM_ROT), 4), 1'b1, rand_byte(), 1'b0);
            step();     // Pulse seen here, one motor only
        end
        for (int i = 0; i < N_MIXED; i++) begin
            if (rand_below(8) == 0)
                randomize_inputs();
            pick = rand_below(4);       // Bit 0 write, bit 1 read
            drive_bus(6'(rand_below(64)), pick[0], rand_byte(), pick[1]);
            step();
        end
        drive_bus('0, 1'b0, '0, 1'b0);
        step();
        $display("Test passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* build.f */
+incdir+design
design/motor_regs_pkg.sv
design/reg_decoder.sv
design/motor_channel.sv
design/angle_tracker.sv
design/reg_read_mux.sv
design/motor_regs_top.sv
sim/motor_regs_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the motor register testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim_run.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f build.f --top-module motor_regs_tb -o motor_regs_sim

# The run may stop with a nonzero status, the log decides
./obj_dir/motor_regs_sim 2>&1 | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation FAILED, see $LOG"
    exit 1
fi
echo "Simulation finished without failures"
